// ==== build.f ====
+incdir+.
vdu_timing_pkg.sv
vdu_mem_pkg.sv
video_timing.sv
host_write_port.sv
video_memory.sv
scanline_fetch.sv
pixel_shifter.sv
vdu_top.sv
vdu_props.sv
tb_vdu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vdu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) vdu_consts.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_vdu.sv ====
// VDU directed testbench
`timescale 1ns/100ps
`include "vdu_consts.svh"

module tb_vdu;
	import vdu_timing_pkg::*;
	import vdu_mem_pkg::*;

	localparam int FRAME_CYCLES   = `VDU_H_TOTAL * `VDU_V_TOTAL;
	localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 2000;   // fill frame plus four more

	logic       clk, reset, host_req, host_ack, frame_start, drawing, pixel;
	host_wr_t   host_wr;
	vdu_mode_e  mode;
	logic [7:0] disp_m [`VDU_DISP_BYTES];    // model of display area
	logic [7:0] font_m [`VDU_FONT_BYTES];    // model of font area
	line_buf_t  cap [`VDU_V_ACTIVE];         // last captured frame
	line_buf_t  frame_a [`VDU_V_ACTIVE];     // first char frame
	int         run_len [`VDU_V_ACTIVE];     // drawing clocks per line
	int         stray_px;                    // pixels seen outside drawing
	int         errors;
	int         cycles;

	vdu_top i_vdu_top (
		.i_clk(clk), .i_reset(reset), .i_host_req(host_req), .i_host_wr(host_wr),
		.o_host_ack(host_ack), .i_mode(mode), .o_frame_start(frame_start),
		.o_drawing(drawing), .o_pixel(pixel));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;               // 4 ns
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	task automatic check_line(input string name, input line_buf_t exp, input line_buf_t act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_ack(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	// one four-phase transaction, model follows
	task automatic host_write(input logic [`VDU_HOST_AW-1:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		host_wr.addr = addr;
		host_wr.data = data;
		host_req     = 1'b1;
		do @(negedge clk); while (!host_ack);
		@(posedge clk);
		#1;
		host_req = 1'b0;
		do @(negedge clk); while (host_ack);
		if (addr[`VDU_HOST_AW-1])
			font_m[addr[`VDU_MEM_AW-1:0]] = data;
		else
			disp_m[addr[`VDU_MEM_AW-1:0]] = data;
	endtask

	// line y from the model, msb-first per cell
	function automatic line_buf_t expected_line(input int y, input vdu_mode_e m, input logic inv_on);
		line_buf_t  l;
		logic [7:0] b, g;
		for (int c = 0; c < `VDU_COLS; c++) begin
			b = disp_m[{5'(y >> 3), 4'(c)}];   // row * 16 + col
			g = font_m[{b[5:0], 3'(y)}];        // glyph * 8 + line
			if (m == MODE_GRAPHICS)
				g = b;
			else if (b[7] && inv_on)
				g = ~g;
			l[`VDU_H_PIXELS - 1 - 8 * c -: 8] = g;
		end
		return l;
	endfunction

	// one frame from frame_start to the end of the last visible line
	task automatic capture_frame();
		int   line;
		int   n;
		int   lead;
		logic prev;
		logic done;
		line     = -1;
		n        = 0;
		lead     = 0;
		prev     = 1'b0;
		done     = 1'b0;
		stray_px = 0;
		do @(negedge clk); while (!frame_start);
		while (!done) begin
			@(negedge clk);
			if (line < 0)
				lead++;                          // clocks since frame_start
			if (drawing && !prev) begin
				if (line < 0)
					check_count("frame_start to first pixel", `VDU_H_START - 1, lead);
				line++;                          // new line starts
				n = 0;
			end
			if (drawing) begin
				cap[line] = {cap[line][`VDU_H_PIXELS-2:0], pixel};
				n++;
			end else begin
				if (pixel)
					stray_px++;
				if (prev) begin
					run_len[line] = n;
					done = (line == `VDU_V_ACTIVE - 1);
				end
			end
			prev = drawing;
		end
	endtask

	task automatic test_handshake();
		int writes;
		writes = 0;
		@(posedge clk);
		#1;
		host_wr.addr = 10'h005;
		host_wr.data = 8'($urandom);
		host_req     = 1'b1;
		do begin
			@(negedge clk);
			writes += int'(i_vdu_top.mem_wr.en);
		end while (!host_ack);
		repeat (6) begin                     // slow host keeps req high
			@(negedge clk);
			check_ack("handshake ack held", 1'b1, host_ack);
			writes += int'(i_vdu_top.mem_wr.en);
		end
		check_count("handshake writes", 1, writes);
		disp_m[9'h005] = host_wr.data;
		@(posedge clk);
		#1;
		host_req = 1'b0;
		@(negedge clk);
		check_ack("handshake ack before req seen", 1'b1, host_ack);
		@(negedge clk);
		check_ack("handshake ack after req seen", 1'b0, host_ack);
		while (host_ack)
			@(negedge clk);
		host_write(10'h006, 8'($urandom));   // second transaction
	endtask

	task automatic test_char_mode();
		int lines [4] = '{0, 7, 8, 255};
		foreach (lines[i])
			check_line($sformatf("char_mode line %0d", lines[i]),
				expected_line(lines[i], MODE_CHAR, 1'b1), cap[lines[i]]);
	endtask

	task automatic test_invert();
		line_buf_t mask;
		for (int y = 8; y < 16; y++) begin
			mask = '0;
			for (int c = 0; c < `VDU_COLS; c++)
				if (disp_m[{5'd1, 4'(c)}][7])
					mask[`VDU_H_PIXELS - 1 - 8 * c -: 8] = 8'hff;
			check_line($sformatf("invert line %0d", y), mask,
				cap[y] ^ expected_line(y, MODE_CHAR, 1'b0));
		end
	endtask

	task automatic test_drawing_window();
		for (int y = 0; y < `VDU_V_ACTIVE; y++)
			check_count($sformatf("drawing_window line %0d", y), `VDU_H_PIXELS, run_len[y]);
		check_count("drawing_window stray pixels", 0, stray_px);
	endtask

	task automatic test_write_during_display();
		logic [8:0] a;
		line_buf_t  mask;
		a    = {5'd2, 4'd9};                 // row 2, column 9
		mask = '0;
		mask[`VDU_H_PIXELS - 1 - 8 * 9 -: 8] = 8'hff;
		do @(negedge clk); while (!frame_start);
		repeat (40) begin                    // past row 2 of this frame
			do @(negedge clk); while (!drawing);
			do @(negedge clk); while (drawing);
		end
		host_write({1'b0, a}, disp_m[a] ^ 8'h80);   // flip invert only
		capture_frame();
		for (int y = 16; y < 24; y++) begin
			check_line($sformatf("write_during_display diff %0d", y), mask, cap[y] ^ frame_a[y]);
			check_line($sformatf("write_during_display line %0d", y),
				expected_line(y, MODE_CHAR, 1'b1), cap[y]);
		end
	endtask

	task automatic test_graphics();
		for (int y = 0; y < `VDU_V_ACTIVE; y++) begin
			check_line($sformatf("graphics line %0d", y),
				expected_line(y, MODE_GRAPHICS, 1'b1), cap[y]);
			if (y % 8 != 0)
				check_line($sformatf("graphics repeat %0d", y), cap[y - y % 8], cap[y]);
		end
	endtask

	initial begin
		logic [7:0] d;
		void'($urandom(32'h16ea74e8));
		errors   = 0;
		reset    = 1'b1;
		host_req = 1'b0;
		host_wr  = '0;
		mode     = MODE_CHAR;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int a = 0; a < `VDU_FONT_BYTES; a++)
			host_write({1'b1, 9'(a)}, 8'($urandom));   // random glyphs
		for (int a = 0; a < `VDU_DISP_BYTES; a++) begin
			d    = 8'($urandom);
			d[7] = a[0];                     // odd columns inverted
			host_write({1'b0, 9'(a)}, d);
		end
		test_handshake();
		capture_frame();
		frame_a = cap;
		test_char_mode();
		test_invert();
		test_drawing_window();
		test_write_during_display();
		@(posedge clk);
		#1;
		mode = MODE_GRAPHICS;                // latched on next frame_start
		capture_frame();
		test_graphics();
		test_drawing_window();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== vdu_props.sv ====
// VDU handshake and pixel assertions
`timescale 1ns/100ps

module vdu_props (
	input logic i_clk,
	input logic i_reset,
	input logic i_req,
	input logic i_ack,
	input logic i_drawing,
	input logic i_pixel
);

	ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
		$rose(i_ack) |-> i_req) else $error("ack rose without req");

	ack_holds: assert property (@(posedge i_clk) disable iff (i_reset)
		i_ack && i_req |=> i_ack) else $error("ack fell while req high");

	pixel_dark: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_drawing |-> !i_pixel) else $error("pixel set outside drawing window");

endmodule

bind host_write_port vdu_props props_handshake (.i_clk, .i_reset, .i_req, .i_ack(o_ack),
	.i_drawing(1'b0), .i_pixel(1'b0));
bind pixel_shifter vdu_props props_pixel (.i_clk, .i_reset, .i_req(1'b0), .i_ack(1'b0),
	.i_drawing(o_drawing), .i_pixel(o_pixel));

// ==== vdu_top.sv ====
// VDU top level
`timescale 1ns/100ps
`include "vdu_consts.svh"

module vdu_top (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_host_req,
	input  vdu_mem_pkg::host_wr_t     i_host_wr,
	output logic                      o_host_ack,
	input  vdu_timing_pkg::vdu_mode_e i_mode,
	output logic                      o_frame_start,
	output logic                      o_drawing,
	output logic                      o_pixel
);
	import vdu_timing_pkg::*;
	import vdu_mem_pkg::*;

	raster_t    raster;
	mem_wr_t    mem_wr;
	cell_u      disp_data;
	line_buf_t  line_buf;
	logic [`VDU_MEM_AW-1:0] disp_addr, font_addr;
	logic [7:0] font_data;

	video_timing i_video_timing (.i_clk, .i_reset, .o_raster(raster));

	host_write_port i_host_write_port (
		.i_clk, .i_reset,
		.i_req(i_host_req), .i_wr(i_host_wr),
		.o_ack(o_host_ack), .o_mem_wr(mem_wr));

	video_memory i_video_memory (
		.i_clk, .i_mem_wr(mem_wr),
		.i_disp_addr(disp_addr), .o_disp_data(disp_data),
		.i_font_addr(font_addr), .o_font_data(font_data));

	scanline_fetch i_scanline_fetch (
		.i_clk, .i_reset, .i_raster(raster), .i_mode,
		.o_disp_addr(disp_addr), .i_disp_data(disp_data),
		.o_font_addr(font_addr), .i_font_data(font_data),
		.o_line_buf(line_buf));

	pixel_shifter i_pixel_shifter (
		.i_clk, .i_reset, .i_raster(raster), .i_line_buf(line_buf),
		.o_drawing, .o_pixel);

	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_frame_start <= 1'b0;
		else
			o_frame_start <= raster.frame_start;   // one clock behind raster
	end

endmodule

// ==== pixel_shifter.sv ====
// VDU pixel shifter
`timescale 1ns/100ps
`include "vdu_consts.svh"

module pixel_shifter (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  vdu_timing_pkg::raster_t i_raster,
	input  vdu_mem_pkg::line_buf_t  i_line_buf,
	output logic                    o_drawing,   // 128 clocks per visible line
	output logic                    o_pixel
);
	import vdu_timing_pkg::*;
	import vdu_mem_pkg::*;

	line_buf_t shreg;                    // own copy, fetcher may refill
	logic [$clog2(`VDU_H_PIXELS)-1:0] cnt;
	logic load;

	assign load = !o_drawing && i_raster.visible_line &&
	              (i_raster.sx == sx_t'(`VDU_H_START - 1));

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_drawing <= 1'b0;
			cnt       <= '0;
		end else if (load) begin
			o_drawing <= 1'b1;           // first pixel at H_START
			cnt       <= '0;
		end else if (o_drawing) begin
			cnt <= cnt + 1'b1;
			if (cnt == $bits(cnt)'(`VDU_H_PIXELS - 1))
				o_drawing <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load)
			shreg <= i_line_buf;
		else if (o_drawing)
			shreg <= shreg << 1;         // msb out first
	end

	assign o_pixel = o_drawing & shreg[`VDU_H_PIXELS-1];

endmodule

// ==== scanline_fetch.sv ====
// VDU scanline fetcher
`timescale 1ns/100ps
`include "vdu_consts.svh"

module scanline_fetch (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  vdu_timing_pkg::raster_t   i_raster,
	input  vdu_timing_pkg::vdu_mode_e i_mode,
	output logic [`VDU_MEM_AW-1:0]    o_disp_addr,
	input  vdu_mem_pkg::cell_u        i_disp_data,
	output logic [`VDU_MEM_AW-1:0]    o_font_addr,
	input  logic [7:0]                i_font_data,
	output vdu_mem_pkg::line_buf_t    o_line_buf
);
	import vdu_timing_pkg::*;
	import vdu_mem_pkg::*;

	localparam int COL_W = $clog2(`VDU_COLS);

	vdu_mode_e  mode_q;                  // frame mode
	logic [COL_W-1:0] col;               // issue column
	logic [COL_W-1:0] col1, col2;        // column per stage
	logic       v0, v1, v2;              // stage valids
	cell_u      cell2;                   // display byte at stage 2
	logic [7:0] cell_bits;               // decoded pixels for the buffer

	// mode only changes on frame boundary
	always_ff @(posedge i_clk) begin
		if (i_reset)
			mode_q <= MODE_CHAR;
		else if (i_raster.frame_start)
			mode_q <= i_mode;
	end

	// issue 16 cell addresses back to back after line_start
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			v0  <= 1'b0;
			col <= '0;
		end else if (i_raster.line_start && i_raster.visible_line) begin
			v0  <= 1'b1;
			col <= '0;
		end else if (v0) begin
			col <= col + 1'b1;
			if (col == COL_W'(`VDU_COLS - 1))
				v0 <= 1'b0;              // last cell issued
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
		end else begin
			v1 <= v0;                    // display data back next clock
			v2 <= v1;                    // font data back next clock
		end
	end

	always_ff @(posedge i_clk) begin
		col1  <= col;
		col2  <= col1;
		cell2 <= i_disp_data;            // kept for graphics and invert
	end

	// row = sy / 8, glyph line = sy % 8
	assign o_disp_addr = {i_raster.sy[7:3], col};
	assign o_font_addr = {i_disp_data.chr.code, i_raster.sy[2:0]};

	always_comb begin
		if (mode_q == MODE_GRAPHICS)
			cell_bits = cell2.pix;       // raw byte, font ignored
		else if (cell2.chr.invert)
			cell_bits = ~i_font_data;
		else
			cell_bits = i_font_data;
	end

	// stage 3 writes the byte, cell 0 at the top
	always_ff @(posedge i_clk) begin
		if (v2)
			o_line_buf[`VDU_H_PIXELS - 1 - 8 * col2 -: 8] <= cell_bits;
	end

endmodule

// ==== video_memory.sv ====
// VDU video memory
`timescale 1ns/100ps
`include "vdu_consts.svh"

module video_memory (
	input  logic                   i_clk,
	input  vdu_mem_pkg::mem_wr_t   i_mem_wr,
	input  logic [`VDU_MEM_AW-1:0] i_disp_addr,  // row * 16 + col
	output vdu_mem_pkg::cell_u     o_disp_data,
	input  logic [`VDU_MEM_AW-1:0] i_font_addr,  // glyph * 8 + line
	output logic [7:0]             o_font_data
);

	logic [7:0] disp_mem [`VDU_DISP_BYTES];   // character or pixel bytes
	logic [7:0] font_mem [`VDU_FONT_BYTES];   // glyph rows, msb leftmost

	// host writes, steered by area select
	always_ff @(posedge i_clk) begin
		if (i_mem_wr.en && !i_mem_wr.font_sel)
			disp_mem[i_mem_wr.addr] <= i_mem_wr.data;
		if (i_mem_wr.en && i_mem_wr.font_sel)
			font_mem[i_mem_wr.addr] <= i_mem_wr.data;
	end

	// registered read ports, one clock latency
	always_ff @(posedge i_clk) begin
		o_disp_data <= disp_mem[i_disp_addr];     // old data on same-cycle write
		o_font_data <= font_mem[i_font_addr];
	end

endmodule

// ==== host_write_port.sv ====
// VDU host write port
`timescale 1ns/100ps
`include "vdu_consts.svh"

module host_write_port (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_req,      // four-phase request
	input  vdu_mem_pkg::host_wr_t i_wr,       // held by host while req high
	output logic                  o_ack,
	output vdu_mem_pkg::mem_wr_t  o_mem_wr
);
	import vdu_mem_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,                          // wait for req
		S_WRITE,                         // one write cycle
		S_ACK                            // ack high until req drops
	} hwp_state_e;

	hwp_state_e state;
	host_wr_t   wr_q;                    // captured request

	always_ff @(posedge i_clk) begin
		if (i_reset)
			state <= S_IDLE;
		else begin
			case (state)
				S_IDLE:  if (i_req) state <= S_WRITE;
				S_WRITE: state <= S_ACK;          // exactly one write
				S_ACK:   if (!i_req) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == S_IDLE && i_req)
			wr_q <= i_wr;                // no reset, payload only
	end

	assign o_ack = (state == S_ACK);

	// split host address into area select and array address
	always_comb begin
		o_mem_wr.en       = (state == S_WRITE);
		o_mem_wr.font_sel = wr_q.addr[`VDU_HOST_AW-1];
		o_mem_wr.addr     = wr_q.addr[`VDU_MEM_AW-1:0];
		o_mem_wr.data     = wr_q.data;
	end

endmodule

// ==== video_timing.sv ====
// VDU raster generator
`timescale 1ns/100ps
`include "vdu_consts.svh"

module video_timing (
	input  logic                     i_clk,
	input  logic                     i_reset,
	output vdu_timing_pkg::raster_t  o_raster
);
	import vdu_timing_pkg::*;

	sx_t  sx_next;
	sy_t  sy_next;
	logic line_wrap;                     // last clock of the line

	always_comb begin
		line_wrap = (o_raster.sx == sx_t'(`VDU_H_TOTAL - 1));
		sx_next   = line_wrap ? '0 : o_raster.sx + 1'b1;
		if (!line_wrap)
			sy_next = o_raster.sy;
		else if (o_raster.sy == sy_t'(`VDU_V_TOTAL - 1))
			sy_next = '0;                    // wrap frame
		else
			sy_next = o_raster.sy + 1'b1;
	end

	// strobes decoded from next position so they line up with the counts
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_raster.sx           <= '0;
			o_raster.sy           <= '0;
			o_raster.line_start   <= 1'b1;   // reset lands on sx 0 of line 0
			o_raster.frame_start  <= 1'b1;
			o_raster.visible_line <= 1'b1;
		end else begin
			o_raster.sx           <= sx_next;
			o_raster.sy           <= sy_next;
			o_raster.line_start   <= (sx_next == '0);
			o_raster.frame_start  <= (sx_next == '0) && (sy_next == '0);
			o_raster.visible_line <= (sy_next < sy_t'(`VDU_V_ACTIVE));
		end
	end

endmodule

// ==== vdu_mem_pkg.sv ====
// VDU memory types
`include "vdu_consts.svh"

package vdu_mem_pkg;

	typedef struct packed {
		logic [`VDU_HOST_AW-1:0] addr;   // bit 9 selects font area
		logic [7:0]              data;
	} host_wr_t;

	typedef struct packed {
		logic                   en;        // single cycle strobe
		logic                   font_sel;  // 0 display, 1 font
		logic [`VDU_MEM_AW-1:0] addr;
		logic [7:0]             data;
	} mem_wr_t;

	typedef struct packed {
		logic       invert;              // complement glyph row
		logic       unused;
		logic [5:0] code;                // glyph index
	} char_cell_t;

	// one display byte, read as a character or as raw pixels
	typedef union packed {
		char_cell_t chr;
		logic [7:0] pix;                 // msb is leftmost
	} cell_u;

	typedef logic [`VDU_H_PIXELS-1:0] line_buf_t;   // cell 0 in bits 127..120

endpackage

// ==== vdu_timing_pkg.sv ====
// VDU raster types
`include "vdu_consts.svh"

package vdu_timing_pkg;

	typedef logic [$clog2(`VDU_H_TOTAL)-1:0] sx_t;   // 8 bits
	typedef logic [$clog2(`VDU_V_TOTAL)-1:0] sy_t;   // 9 bits

	typedef struct packed {
		sx_t  sx;                        // pixel count in line
		sy_t  sy;                        // line count in frame
		logic line_start;                // sx == 0
		logic frame_start;               // sx == 0 on line 0
		logic visible_line;              // sy below active height
	} raster_t;

	typedef enum logic {
		MODE_CHAR     = 1'b0,            // glyph lookup
		MODE_GRAPHICS = 1'b1             // raw pixel bytes
	} vdu_mode_e;

endpackage

// ==== vdu_consts.svh ====
// VDU size constants
`ifndef VDU_CONSTS_SVH
`define VDU_CONSTS_SVH

// raster, shrunk for simulation
`define VDU_H_TOTAL   176                // clocks per line
`define VDU_H_START   32                 // sx of first visible pixel
`define VDU_H_PIXELS  128                // visible pixels per line
`define VDU_V_TOTAL   264                // lines per frame
`define VDU_V_ACTIVE  256                // visible lines

// cell grid and font
`define VDU_COLS      16                 // cells per row
`define VDU_ROWS      32                 // rows per screen
`define VDU_FONT_H    8                  // glyph height in lines
`define VDU_GLYPHS    64                 // glyphs in font area

// memory geometry
`define VDU_DISP_BYTES (`VDU_COLS * `VDU_ROWS)      // 512
`define VDU_FONT_BYTES (`VDU_GLYPHS * `VDU_FONT_H)  // 512
`define VDU_MEM_AW    9                  // array address width
`define VDU_HOST_AW   10                 // host address, msb picks area

`endif
